// ==== files.f ====
verilog/k051960_pkg.sv
verilog/sprite_cpu_regs.sv
verilog/raster_timing.sv
verilog/int_flags.sv
verilog/rom_readback.sv
verilog/k051960_top.sv
verification/tb_k051960.sv

// ==== verification/tb_k051960.sv ====
`timescale 1ns/1ps
// ------------------------------
// Sprite generator testbench
// Raster, register and interrupt model with random CPU traffic
// ------------------------------
module tb_k051960
	import k051960_pkg::*;
;

	localparam int LINE_CYCLES  = 384;
	localparam int FRAME_CYCLES = 101376;

	logic clk_6M, RES_SYNC, obcs, rd, wr;
	cpu_addr_t ab;
	cpu_data_t db_in, db_out;
	logic db_dir, p1h, p2h, frame_sync_n, rst, irq_n, firq_n, nmi_n;
	rom_addr_t ca;
	color_t oc;

	// Reference model state
	h_count_t m_h;
	v_count_t m_v;
	int m_starts;
	cpu_data_t m_ctrl, m_reg2, m_reg3;
	logic [1:0] m_reg4;
	logic [7:0] m_latch;
	logic [2:0] m_flag_n, m_pulse;

	logic [31:0] lcg_state;
	int errors, checks, cycle, low_len, last_fall, falls, n;
	logic checking, fs_prev, p1h_prev;
	cpu_data_t r2, r3, r4;
	cpu_addr_t addr;
	logic [2:0] flags;

	k051960_top i_dut (
		.clk_6M(clk_6M), .RES_SYNC(RES_SYNC), .ab(ab), .db_in(db_in), .obcs(obcs),
		.rd(rd), .wr(wr), .db_out(db_out), .db_dir(db_dir), .p1h(p1h), .p2h(p2h),
		.frame_sync_n(frame_sync_n), .rst(rst), .irq_n(irq_n), .firq_n(firq_n),
		.nmi_n(nmi_n), .ca(ca), .oc(oc)
	);

	initial begin
		clk_6M = 1'b0;
		forever #10 clk_6M = ~clk_6M;
	end

	// Line events, IRQ at bit 0 up to NMI at bit 2
	assign m_pulse = {(m_h == H_FIRST) && (m_v[4:0] == 5'd0),
		(m_h == H_FIRST) && m_v[0], (m_h == H_FIRST) && (m_v == VBL_START)};

	always @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			m_h <= H_FIRST;
			m_v <= V_FIRST;
			m_starts <= 0;
			m_ctrl <= '0;
			m_reg2 <= '0;
			m_reg3 <= '0;
			m_reg4 <= '0;
			m_latch <= '0;
			m_flag_n <= 3'b111;
		end else begin
			m_h <= (m_h == H_LAST) ? H_FIRST : h_count_t'(m_h + 1);
			if (m_h == H_LAST) begin
				m_v <= (m_v == V_LAST) ? V_FIRST : v_count_t'(m_v + 1);
			end
			if (m_pulse[0]) begin
				m_starts <= m_starts + 1;
			end
			if (!obcs && wr && ab[10:3] == 8'h00) begin
				case (ab[2:0])
					REG_CTRL: m_ctrl <= db_in;
					REG_ROM_LO: m_reg2 <= db_in;
					REG_ROM_HI: m_reg3 <= db_in;
					REG_ROM_X: m_reg4 <= db_in[1:0];
					default: ;
				endcase
			end
			if (!obcs && rd && ab[10] && m_ctrl[CTRL_ROM_READ]) begin
				m_latch <= ab[9:2];
			end
			for (int i = 0; i < 3; i++) begin
				if (!m_ctrl[i]) begin
					m_flag_n[i] <= 1'b1;
				end else if (m_pulse[i]) begin
					m_flag_n[i] <= 1'b0;
				end
			end
		end
	end

	function automatic logic [15:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_outputs();
		logic read0;
		logic exp_dir;
		read0 = !obcs && rd && (ab == '0);
		exp_dir = read0 || (!obcs && rd && ab[10] && m_ctrl[CTRL_ROM_READ]);
		check_value("p1h", p1h, m_h[0]);
		check_value("p1h toggle", p1h, !p1h_prev);
		check_value("p2h", p2h, m_h[1]);
		check_value("frame_sync_n", frame_sync_n, m_v != V_LAST);
		check_value("rst", rst, m_starts >= RST_FRAMES);
		check_value("interrupt flags", {nmi_n, firq_n, irq_n}, m_flag_n);
		check_value("db_dir", db_dir, exp_dir);
		if (read0) begin
			check_value("db_out", db_out, {7'b0, !((m_v >= VBL_START) || (m_v < VBL_END))});
		end
		check_value("ca", ca, m_ctrl[CTRL_ROM_READ] ? {m_reg3[1:0], m_reg2, m_latch} : 18'h0);
		check_value("oc", oc, m_ctrl[CTRL_ROM_READ] ? {m_reg4, m_reg3[7:2]} : 8'h00);
		if (!frame_sync_n) begin
			low_len++;
		end
		if (fs_prev && !frame_sync_n) begin
			if (falls > 0) begin
				check_value("frame sync period", cycle - last_fall, FRAME_CYCLES);
			end
			last_fall = cycle;
			falls++;
		end
		if (!fs_prev && frame_sync_n) begin
			check_value("frame sync width", low_len, LINE_CYCLES);
			low_len = 0;
		end
		fs_prev = frame_sync_n;
		p1h_prev = p1h;
	endtask

	task automatic next_cycle();
		@(negedge clk_6M);
		cycle++;
		if (checking) begin
			check_outputs();
		end
	endtask

	task automatic bus_idle();
		obcs = 1'b1;
		rd = 1'b0;
		wr = 1'b0;
		ab = '0;
		db_in = '0;
	endtask

	task automatic write_reg(input logic [2:0] reg_addr, input cpu_data_t data);
		obcs = 1'b0;
		wr = 1'b1;
		ab = cpu_addr_t'(reg_addr);
		db_in = data;
		next_cycle();
		bus_idle();
	endtask

	task automatic wait_flag_low(input int idx, input int limit, input string name);
		int k;
		k = 0;
		flags = {nmi_n, firq_n, irq_n};
		while (flags[idx] && k < limit) begin
			next_cycle();
			k++;
			flags = {nmi_n, firq_n, irq_n};
		end
		if (flags[idx]) begin
			errors++;
			$display("Timeout waiting for %s to go low", name);
		end
	endtask

	initial begin
		lcg_state = 32'd84;
		errors = 0;
		checks = 0;
		cycle = 0;
		low_len = 0;
		last_fall = 0;
		falls = 0;
		checking = 1'b0;
		fs_prev = 1'b1;
		RES_SYNC = 1'b0;
		bus_idle();
		repeat (4) @(posedge clk_6M);
		@(negedge clk_6M);
		RES_SYNC = 1'b1;
		p1h_prev = p1h;
		checking = 1'b1;

		// Random status reads until the delayed reset is released
		n = 0;
		while (rst !== 1'b1 && n < 9 * FRAME_CYCLES) begin
			obcs = rand_next() > 16'h5000;
			rd = rand_next() > 16'h4000;
			addr = cpu_addr_t'(rand_next());
			ab = rand_next() > 16'h8000 ? '0 : addr;
			next_cycle();
			n++;
		end
		bus_idle();
		if (rst !== 1'b1) begin
			errors++;
			$display("Timeout waiting for rst to rise");
		end
		repeat (2 * LINE_CYCLES) next_cycle();

		// ROM readback through registers 2, 3, 4 and the latched address
		for (int t = 0; t < 16; t++) begin
			r2 = cpu_data_t'(rand_next());
			r3 = cpu_data_t'(rand_next());
			r4 = cpu_data_t'(rand_next());
			addr = {1'b1, 10'(rand_next())};
			write_reg(REG_ROM_LO, r2);
			write_reg(REG_ROM_HI, r3);
			write_reg(REG_ROM_X, r4);
			write_reg(REG_CTRL, cpu_data_t'(1 << CTRL_ROM_READ));
			obcs = 1'b0;
			rd = 1'b1;
			ab = addr;
			next_cycle();
			bus_idle();
			next_cycle();
			check_value("readback ca", ca, {r3[1:0], r2, addr[9:2]});
			check_value("readback oc", oc, {r4[1:0], r3[7:2]});
		end
		write_reg(REG_CTRL, 8'h00);
		check_value("ca after readback off", ca, 18'h0);
		check_value("oc after readback off", oc, 8'h00);

		// Each interrupt in turn, then cleared by its enable
		check_value("irq_n before enable", irq_n, 1'b1);
		write_reg(REG_CTRL, cpu_data_t'(1 << CTRL_IRQ_EN));
		wait_flag_low(CTRL_IRQ_EN, FRAME_CYCLES + 8, "irq_n");
		write_reg(REG_CTRL, 8'h00);
		next_cycle();
		check_value("irq_n after clear", irq_n, 1'b1);
		write_reg(REG_CTRL, cpu_data_t'(1 << CTRL_FIRQ_EN));
		wait_flag_low(CTRL_FIRQ_EN, 2 * LINE_CYCLES + 8, "firq_n");
		write_reg(REG_CTRL, 8'h00);
		next_cycle();
		check_value("firq_n after clear", firq_n, 1'b1);
		write_reg(REG_CTRL, cpu_data_t'(1 << CTRL_NMI_EN));
		wait_flag_low(CTRL_NMI_EN, 32 * LINE_CYCLES + 8, "nmi_n");
		write_reg(REG_CTRL, 8'h00);
		next_cycle();
		check_value("nmi_n after clear", nmi_n, 1'b1);

		if (falls < 2) begin
			errors++;
			$display("Frame sync period was never measured");
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/int_flags.sv ====
`timescale 1ns/1ps
// ------------------------------
// Interrupt flags
// Sticky IRQ, FIRQ and NMI requests
// ------------------------------
module int_flags (
	input  logic clk_6M,
	input  logic RES_SYNC,
	input  logic vblank_start,
	input  logic firq_tick,
	input  logic nmi_tick,
	input  logic irq_en,
	input  logic firq_en,
	input  logic nmi_en,
	output logic irq_n,
	output logic firq_n,
	output logic nmi_n
);

	logic [2:0] tick;
	logic [2:0] en;
	logic [2:0] flag_n;

	// Order is IRQ, FIRQ, NMI from bit 0 up
	assign tick = {nmi_tick, firq_tick, vblank_start};
	assign en   = {nmi_en, firq_en, irq_en};

	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			flag_n <= 3'b111;
		end else begin
			for (int i = 0; i < 3; i++) begin
				// Disabled flag is held released
				if (!en[i]) begin
					flag_n[i] <= 1'b1;
				end else if (tick[i]) begin
					flag_n[i] <= 1'b0;
				end
			end
		end
	end

	assign irq_n  = flag_n[0];
	assign firq_n = flag_n[1];
	assign nmi_n  = flag_n[2];

endmodule

// ==== verilog/k051960_pkg.sv ====
// ------------------------------
// Sprite generator definitions
// Widths, raster limits, register map
// ------------------------------
package k051960_pkg;

	// Bus and counter widths
	typedef logic [8:0]  h_count_t;
	typedef logic [8:0]  v_count_t;
	typedef logic [10:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [17:0] rom_addr_t;
	typedef logic [7:0]  color_t;

	// Horizontal counter, 384 pixels per line
	localparam h_count_t H_FIRST = 9'h020;
	localparam h_count_t H_LAST  = 9'h19F;

	// Vertical counter, 264 lines per frame
	localparam v_count_t V_FIRST = 9'h0F8;
	localparam v_count_t V_LAST  = 9'h1FF;

	// Blanking window wraps through the frame end
	localparam v_count_t VBL_START = 9'h1F0;
	localparam v_count_t VBL_END   = 9'h110;

	// Blank starts counted before the system reset is released
	localparam int RST_FRAMES = 8;

	// Register addresses, low three CPU address bits
	localparam logic [2:0] REG_CTRL   = 3'd0;
	localparam logic [2:0] REG_ROM_LO = 3'd2;
	localparam logic [2:0] REG_ROM_HI = 3'd3;
	localparam logic [2:0] REG_ROM_X  = 3'd4;

	// Control register bits
	localparam int CTRL_IRQ_EN   = 0;
	localparam int CTRL_FIRQ_EN  = 1;
	localparam int CTRL_NMI_EN   = 2;
	localparam int CTRL_ROM_READ = 5;

endpackage

// ==== verilog/k051960_top.sv ====
`timescale 1ns/1ps
// ------------------------------
// Sprite generator top level
// CPU registers, raster timing, interrupts and ROM readback
// ------------------------------
module k051960_top
	import k051960_pkg::*;
(
	input  logic      clk_6M,
	input  logic      RES_SYNC,
	input  cpu_addr_t ab,
	input  cpu_data_t db_in,
	input  logic      obcs,
	input  logic      rd,
	input  logic      wr,
	output cpu_data_t db_out,
	output logic      db_dir,
	output logic      p1h,
	output logic      p2h,
	output logic      frame_sync_n,
	output logic      rst,
	output logic      irq_n,
	output logic      firq_n,
	output logic      nmi_n,
	output rom_addr_t ca,
	output color_t    oc
);

	logic      vblank;
	logic      vblank_start;
	logic      firq_tick;
	logic      nmi_tick;
	logic      rom_read;
	logic      rom_latch;
	logic      irq_en;
	logic      firq_en;
	logic      nmi_en;
	cpu_data_t reg2;
	cpu_data_t reg3;
	logic [1:0] reg4;

	sprite_cpu_regs i_regs (
		.clk_6M    (clk_6M),
		.RES_SYNC  (RES_SYNC),
		.ab        (ab),
		.db_in     (db_in),
		.obcs      (obcs),
		.rd        (rd),
		.wr        (wr),
		.vblank    (vblank),
		.db_out    (db_out),
		.db_dir    (db_dir),
		.rom_read  (rom_read),
		.irq_en    (irq_en),
		.firq_en   (firq_en),
		.nmi_en    (nmi_en),
		.reg2      (reg2),
		.reg3      (reg3),
		.reg4      (reg4),
		.rom_latch (rom_latch)
	);

	raster_timing i_timing (
		.clk_6M       (clk_6M),
		.RES_SYNC     (RES_SYNC),
		.p1h          (p1h),
		.p2h          (p2h),
		.frame_sync_n (frame_sync_n),
		.vblank       (vblank),
		.vblank_start (vblank_start),
		.firq_tick    (firq_tick),
		.nmi_tick     (nmi_tick),
		.rst          (rst)
	);

	int_flags i_ints (
		.clk_6M       (clk_6M),
		.RES_SYNC     (RES_SYNC),
		.vblank_start (vblank_start),
		.firq_tick    (firq_tick),
		.nmi_tick     (nmi_tick),
		.irq_en       (irq_en),
		.firq_en      (firq_en),
		.nmi_en       (nmi_en),
		.irq_n        (irq_n),
		.firq_n       (firq_n),
		.nmi_n        (nmi_n)
	);

	// ROM word address comes from CPU address bits 9..2
	rom_readback i_readback (
		.clk_6M    (clk_6M),
		.RES_SYNC  (RES_SYNC),
		.rom_read  (rom_read),
		.rom_latch (rom_latch),
		.ab_lo     (ab[9:2]),
		.reg2      (reg2),
		.reg3      (reg3),
		.reg4      (reg4),
		.ca        (ca),
		.oc        (oc)
	);

endmodule

// ==== verilog/raster_timing.sv ====
`timescale 1ns/1ps
// ------------------------------
// Raster timing
// Counters, blanking, frame sync, line events, reset delay
// ------------------------------
module raster_timing
	import k051960_pkg::*;
(
	input  logic clk_6M,
	input  logic RES_SYNC,
	output logic p1h,
	output logic p2h,
	output logic frame_sync_n,
	output logic vblank,
	output logic vblank_start,
	output logic firq_tick,
	output logic nmi_tick,
	output logic rst
);

	h_count_t   h_cnt;
	v_count_t   v_cnt;
	v_count_t   v_next;
	logic       line_end;
	logic [2:0] frame_cnt;

	assign line_end = (h_cnt == H_LAST);

	// Line count that takes effect at the coming line end
	assign v_next = (v_cnt == V_LAST) ? V_FIRST : v_count_t'(v_cnt + 9'd1);

	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			h_cnt <= H_FIRST;
			v_cnt <= V_FIRST;
		end else begin
			h_cnt <= line_end ? H_FIRST : h_count_t'(h_cnt + 9'd1);
			if (line_end) begin
				v_cnt <= v_next;
			end
		end
	end

	// Events line up with the cycle the new line count appears
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			vblank_start <= 1'b0;
			firq_tick    <= 1'b0;
			nmi_tick     <= 1'b0;
		end else begin
			vblank_start <= line_end && (v_next == VBL_START);
			firq_tick    <= line_end && v_next[0];
			nmi_tick     <= line_end && (v_next[4:0] == 5'd0);
		end
	end

	// Release reset after enough frames have gone by
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			frame_cnt <= 3'd0;
			rst       <= 1'b0;
		end else if (vblank_start && !rst) begin
			frame_cnt <= frame_cnt + 3'd1;
			if (frame_cnt == 3'(RST_FRAMES - 1)) begin
				rst <= 1'b1;
			end
		end
	end

	assign p1h = h_cnt[0];
	assign p2h = h_cnt[1];

	// Low for the whole last line
	assign frame_sync_n = (v_cnt != V_LAST);

	assign vblank = (v_cnt >= VBL_START) || (v_cnt < VBL_END);

endmodule

// ==== verilog/rom_readback.sv ====
`timescale 1ns/1ps
// ------------------------------
// Graphics ROM readback
// CPU driven ROM address and colour
// ------------------------------
module rom_readback
	import k051960_pkg::*;
(
	input  logic       clk_6M,
	input  logic       RES_SYNC,
	input  logic       rom_read,
	input  logic       rom_latch,
	input  logic [7:0] ab_lo,
	input  cpu_data_t  reg2,
	input  cpu_data_t  reg3,
	input  logic [1:0] reg4,
	output rom_addr_t  ca,
	output color_t     oc
);

	logic [7:0] ab_latch;

	// Low ROM address byte from the last readback access
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			ab_latch <= 8'h00;
		end else if (rom_latch) begin
			ab_latch <= ab_lo;
		end
	end

	// Outputs idle at zero outside readback
	assign ca = rom_read ? {reg3[1:0], reg2, ab_latch} : '0;
	assign oc = rom_read ? {reg4, reg3[7:2]} : '0;

endmodule

// ==== verilog/sprite_cpu_regs.sv ====
`timescale 1ns/1ps
// ------------------------------
// CPU register block
// Address decode, registers 0/2/3/4, read data and bus direction
// ------------------------------
module sprite_cpu_regs
	import k051960_pkg::*;
(
	input  logic       clk_6M,
	input  logic       RES_SYNC,
	input  cpu_addr_t  ab,
	input  cpu_data_t  db_in,
	input  logic       obcs,
	input  logic       rd,
	input  logic       wr,
	input  logic       vblank,
	output cpu_data_t  db_out,
	output logic       db_dir,
	output logic       rom_read,
	output logic       irq_en,
	output logic       firq_en,
	output logic       nmi_en,
	output cpu_data_t  reg2,
	output cpu_data_t  reg3,
	output logic [1:0] reg4,
	output logic       rom_latch
);

	logic reg_sel;
	logic reg_wr;
	logic reg0_rd;
	logic rom_rd;

	// Register window is the first eight addresses
	assign reg_sel = !obcs && (ab[10:3] == 8'h00);
	assign reg_wr  = reg_sel && wr;

	// Status read only at address 0
	assign reg0_rd = !obcs && rd && (ab == cpu_addr_t'(REG_CTRL));

	// Upper half of the window maps onto the graphics ROM
	assign rom_rd = !obcs && rd && ab[10];

	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			irq_en   <= 1'b0;
			firq_en  <= 1'b0;
			nmi_en   <= 1'b0;
			rom_read <= 1'b0;
			reg2     <= '0;
			reg3     <= '0;
			reg4     <= '0;
		end else if (reg_wr) begin
			case (ab[2:0])
				REG_CTRL: begin
					irq_en   <= db_in[CTRL_IRQ_EN];
					firq_en  <= db_in[CTRL_FIRQ_EN];
					nmi_en   <= db_in[CTRL_NMI_EN];
					rom_read <= db_in[CTRL_ROM_READ];
				end
				REG_ROM_LO: begin
					reg2 <= db_in;
				end
				REG_ROM_HI: begin
					reg3 <= db_in;
				end
				REG_ROM_X: begin
					// Only two colour bits are kept
					reg4 <= db_in[1:0];
				end
				default: begin
				end
			endcase
		end
	end

	// Bit 0 reads back as "not in blank"
	always_comb begin
		if (reg0_rd) begin
			db_out = {7'b0000000, ~vblank};
		end else begin
			db_out = '0;
		end
	end

	assign db_dir = reg0_rd || (rom_rd && rom_read);

	// Capture the ROM address on each readback access
	assign rom_latch = rom_rd && rom_read;

endmodule
